// File: include/telemetry_settings.svh
`ifndef TELEMETRY_SETTINGS_SVH
`define TELEMETRY_SETTINGS_SVH

// Records per packet, must be a power of two of at least 2
`define TLM_PACKET_SIZE 8

// Record FIFO address bits, 9 gives 512 memory entries
`define TLM_FIFO_ABITS 9

// Bulk-IN endpoint that carries the telemetry stream
`define TLM_ENDPOINT 4'd2

// USB core state code for suspend
`define TLM_USB_SUSPEND 4'h8

`endif

// File: hw/usb_status_pkg.sv
package usb_status_pkg;

  // USB line state, J is 2'b01 in full and high speed
  typedef logic [1:0] line_state_t;

  // Shared by endpoint, tuser, usb, control and phy state fields
  typedef logic [3:0] usb_nibble_t;

  typedef logic [2:0] usb_error_t;
  typedef logic [2:0] event_code_t;

  // Bulk engine state, one-hot
  typedef logic [7:0] blk_onehot_t;
  typedef logic [2:0] blk_code_t;

  localparam line_state_t LINE_J = 2'b01;

  // Event codes above the raw error codes
  localparam event_code_t EV_TIMEOUT = 3'd7;
  localparam event_code_t EV_SUSPEND = 3'd6;
  localparam event_code_t EV_SENT    = 3'd5;
  localparam event_code_t EV_RECV    = 3'd4;
  localparam event_code_t EV_TOKEN   = 3'd3;

  // Not a valid one-hot pattern
  localparam blk_code_t BLK_INVALID = 3'd7;

endpackage

// File: hw/telemetry_pkg.sv
`include "telemetry_settings.svh"

package telemetry_pkg;

  // One encoded status snapshot
  typedef logic [31:0] record_t;

  // FIFO fill level, counts the output register too
  typedef logic [`TLM_FIFO_ABITS:0] level_t;

  // One lane of the bulk-IN byte stream
  typedef logic [7:0] byte_t;

  // Serializer states
  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

endpackage

// File: hw/telemetry_snapshot.sv
`include "telemetry_settings.svh"

module telemetry_snapshot (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        usb_enum_i,
  input  logic                        usb_reset_i,
  input  logic                        usb_sof_i,
  input  logic                        usb_sent_i,
  input  logic                        usb_recv_i,
  input  logic                        tok_recv_i,
  input  logic                        high_speed_i,
  input  logic                        crc_error_i,
  input  logic                        timeout_i,
  input  usb_status_pkg::line_state_t line_state_i,
  input  usb_status_pkg::usb_nibble_t usb_endpt_i,
  input  usb_status_pkg::usb_nibble_t usb_tuser_i,
  input  usb_status_pkg::usb_nibble_t phy_state_i,
  input  usb_status_pkg::usb_nibble_t usb_state_i,
  input  usb_status_pkg::usb_nibble_t ctl_state_i,
  input  usb_status_pkg::usb_error_t  usb_error_i,
  input  usb_status_pkg::blk_onehot_t blk_state_i,
  input  logic                        rec_ready_i,
  output logic                        rec_valid_o,
  output telemetry_pkg::record_t      rec_data_o,
  output logic                        rec_last_o
);

  import usb_status_pkg::*;
  import telemetry_pkg::*;

  localparam int unsigned CBITS = $clog2(`TLM_PACKET_SIZE);

  event_code_t      event_code;
  blk_code_t        blk_code;

  logic             sof_in_q;
  logic [7:0]       sof_count_q;
  logic [8:0]       sof_sum;
  logic             sof_rise;
  logic             sof_mark;

  logic             usb_reset_q;
  usb_nibble_t      usb_endpt_q;
  usb_nibble_t      usb_tuser_q;
  usb_nibble_t      usb_state_q;
  logic             crc_error_q;
  event_code_t      event_code_q;
  logic             sof_mark_q;
  blk_code_t        blk_code_q;
  usb_nibble_t      ctl_state_q;
  usb_nibble_t      phy_state_q;

  record_t          curr_rec;
  logic [28:0]      prev_fields;
  logic [CBITS-1:0] count_q;

  always_comb begin
    if (timeout_i) begin
      event_code = EV_TIMEOUT;
    end else if (usb_state_i == `TLM_USB_SUSPEND) begin
      event_code = EV_SUSPEND;
    end else if (usb_sent_i) begin
      event_code = EV_SENT;
    end else if (usb_recv_i) begin
      event_code = EV_RECV;
    end else if (tok_recv_i) begin
      event_code = EV_TOKEN;
    end else begin
      event_code = usb_error_i;
    end
  end

  always_comb begin
    case (blk_state_i)
      8'h01:   blk_code = 3'd0;
      8'h02:   blk_code = 3'd1;
      8'h04:   blk_code = 3'd2;
      8'h08:   blk_code = 3'd3;
      8'h10:   blk_code = 3'd4;
      8'h20:   blk_code = 3'd5;
      8'h40:   blk_code = 3'd6;
      default: blk_code = BLK_INVALID;
    endcase
  end

  // High speed has eight SOFs per frame time, so it steps by one instead of eight
  assign sof_rise = usb_sof_i && !sof_in_q;
  assign sof_sum  = {1'b0, sof_count_q} + (high_speed_i ? 9'd1 : 9'd8);
  assign sof_mark = sof_rise && sof_sum[8];

  always_ff @(posedge clock) begin
    if (reset) begin
      sof_in_q    <= 1'b0;
      sof_count_q <= 8'd0;
    end else begin
      sof_in_q <= usb_sof_i;
      if (sof_rise) begin
        sof_count_q <= sof_sum[7:0];
      end
    end
  end

  assign curr_rec = {1'b0, line_state_i, usb_reset_i, usb_endpt_i, usb_tuser_i, usb_state_i,
                     crc_error_i, event_code, sof_mark, blk_code, ctl_state_i, phy_state_i};
  assign prev_fields = {usb_reset_q, usb_endpt_q, usb_tuser_q, usb_state_q, crc_error_q,
                        event_code_q, sof_mark_q, blk_code_q, ctl_state_q, phy_state_q};

  // Line state sits above bit 28 and never triggers a record on its own
  assign rec_valid_o = usb_enum_i && (curr_rec[28:0] != prev_fields);
  assign rec_data_o  = curr_rec;
  assign rec_last_o  = (count_q == CBITS'(`TLM_PACKET_SIZE - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      usb_reset_q  <= 1'b0;
      usb_endpt_q  <= '0;
      usb_tuser_q  <= '0;
      usb_state_q  <= '0;
      crc_error_q  <= 1'b0;
      event_code_q <= '0;
      sof_mark_q   <= 1'b0;
      blk_code_q   <= '0;
      ctl_state_q  <= '0;
      phy_state_q  <= '0;
    end else begin
      usb_reset_q  <= usb_reset_i;
      usb_endpt_q  <= usb_endpt_i;
      usb_tuser_q  <= usb_tuser_i;
      usb_state_q  <= usb_state_i;
      crc_error_q  <= crc_error_i;
      event_code_q <= event_code;
      sof_mark_q   <= sof_mark;
      blk_code_q   <= blk_code;
      ctl_state_q  <= ctl_state_i;
      phy_state_q  <= phy_state_i;
    end
  end

  // Packet position, dropped records do not count
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
    end else if (rec_valid_o && rec_ready_i) begin
      count_q <= count_q + CBITS'(1);
    end
  end

endmodule

// File: hw/telemetry_fifo.sv
`include "telemetry_settings.svh"

module telemetry_fifo (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   wr_valid_i,
  input  telemetry_pkg::record_t wr_data_i,
  input  logic                   wr_last_i,
  output logic                   wr_ready_o,
  output logic                   rd_valid_o,
  input  logic                   rd_ready_i,
  output telemetry_pkg::record_t rd_data_o,
  output logic                   rd_last_o,
  output telemetry_pkg::level_t  level_o
);

  import telemetry_pkg::*;

  localparam int unsigned ABITS = `TLM_FIFO_ABITS;
  localparam int unsigned DEPTH = 1 << ABITS;

  // Packet-last bit rides above the record
  logic [32:0]    mem [DEPTH];
  logic [32:0]    out_q;
  logic           out_valid_q;

  logic [ABITS:0] wr_ptr_q;
  logic [ABITS:0] rd_ptr_q;
  logic           mem_empty;
  logic           mem_full;
  logic           push;
  logic           load;
  logic           pop;
  level_t         level_q;

  assign mem_empty = (wr_ptr_q == rd_ptr_q);
  assign mem_full  = (wr_ptr_q[ABITS] != rd_ptr_q[ABITS]) &&
                     (wr_ptr_q[ABITS-1:0] == rd_ptr_q[ABITS-1:0]);

  assign wr_ready_o = !mem_full;
  assign push       = wr_valid_i && !mem_full;
  assign pop        = out_valid_q && rd_ready_i;
  // Refill the output word when it is empty or leaving this cycle
  assign load       = !mem_empty && (!out_valid_q || rd_ready_i);

  assign rd_valid_o              = out_valid_q;
  assign {rd_last_o, rd_data_o}  = out_q;
  assign level_o                 = level_q;

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr_q[ABITS-1:0]] <= {wr_last_i, wr_data_i};
    end
    if (load) begin
      out_q <= mem[rd_ptr_q[ABITS-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      out_valid_q <= 1'b0;
      level_q     <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (load) begin
        rd_ptr_q    <= rd_ptr_q + 1'b1;
        out_valid_q <= 1'b1;
      end else if (pop) begin
        out_valid_q <= 1'b0;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + level_t'(1);
        2'b01:   level_q <= level_q - level_t'(1);
        default: level_q <= level_q;
      endcase
    end
  end

endmodule

// File: hw/telemetry_bulk_tx.sv
`include "telemetry_settings.svh"

module telemetry_bulk_tx (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        usb_enum_i,
  input  logic                        select_i,
  input  logic                        start_i,
  input  usb_status_pkg::usb_nibble_t endpt_i,
  input  logic                        word_valid_i,
  output logic                        word_ready_o,
  input  telemetry_pkg::record_t      word_data_i,
  input  logic                        word_last_i,
  output logic                        tvalid_o,
  input  logic                        tready_i,
  output telemetry_pkg::byte_t        tdata_o,
  output logic                        tlast_o
);

  import telemetry_pkg::*;

  tx_state_e  state_q;
  record_t    word_q;
  logic       last_q;
  logic [1:0] idx_q;
  logic       sel_q;
  logic       take;
  logic       send;
  logic       start_hit;

  assign start_hit = usb_enum_i && start_i && select_i && (endpt_i == `TLM_ENDPOINT);

  assign word_ready_o = sel_q && (state_q == TX_IDLE);
  assign tvalid_o     = sel_q && (state_q == TX_SEND);
  assign tdata_o      = word_q[7:0];
  assign tlast_o      = last_q && (idx_q == 2'd3);

  assign take = word_valid_i && word_ready_o;
  assign send = tvalid_o && tready_i;

  // Endpoint selection, held until the end of a packet
  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= 1'b0;
    end else if (start_hit) begin
      sel_q <= 1'b1;
    end else if (send && tlast_o) begin
      sel_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= TX_IDLE;
      idx_q   <= 2'd0;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (take) begin
            state_q <= TX_SEND;
            idx_q   <= 2'd0;
            last_q  <= word_last_i;
          end
        end
        TX_SEND: begin
          if (send) begin
            if (idx_q == 2'd3) begin
              state_q <= TX_IDLE;
              last_q  <= 1'b0;
            end
            idx_q <= idx_q + 2'd1;
          end
        end
        default: begin
          state_q <= TX_IDLE;
        end
      endcase
    end
  end

  // Lowest byte first
  always_ff @(posedge clock) begin
    if (take) begin
      word_q <= word_data_i;
    end else if (send) begin
      word_q <= {8'h00, word_q[31:8]};
    end
  end

endmodule

// File: hw/bulk_telemetry_top.sv
module bulk_telemetry_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        usb_enum_i,
  input  logic                        usb_reset_i,
  input  logic                        usb_sof_i,
  input  logic                        usb_sent_i,
  input  logic                        usb_recv_i,
  input  logic                        tok_recv_i,
  input  logic                        high_speed_i,
  input  logic                        crc_error_i,
  input  logic                        timeout_i,
  input  usb_status_pkg::line_state_t line_state_i,
  input  usb_status_pkg::usb_nibble_t usb_endpt_i,
  input  usb_status_pkg::usb_nibble_t usb_tuser_i,
  input  usb_status_pkg::usb_nibble_t phy_state_i,
  input  usb_status_pkg::usb_nibble_t usb_state_i,
  input  usb_status_pkg::usb_nibble_t ctl_state_i,
  input  usb_status_pkg::usb_error_t  usb_error_i,
  input  usb_status_pkg::blk_onehot_t blk_state_i,
  input  logic                        select_i,
  input  logic                        start_i,
  input  usb_status_pkg::usb_nibble_t endpt_i,
  input  logic                        tready_i,
  output logic                        tvalid_o,
  output telemetry_pkg::byte_t        tdata_o,
  output logic                        tlast_o,
  output telemetry_pkg::level_t       level_o
);

  import telemetry_pkg::*;

  logic    rec_valid;
  logic    rec_ready;
  record_t rec_data;
  logic    rec_last;

  logic    word_valid;
  logic    word_ready;
  record_t word_data;
  logic    word_last;

  telemetry_snapshot u_snapshot (
    .clock       (clock),
    .reset       (reset),
    .usb_enum_i  (usb_enum_i),
    .usb_reset_i (usb_reset_i),
    .usb_sof_i   (usb_sof_i),
    .usb_sent_i  (usb_sent_i),
    .usb_recv_i  (usb_recv_i),
    .tok_recv_i  (tok_recv_i),
    .high_speed_i(high_speed_i),
    .crc_error_i (crc_error_i),
    .timeout_i   (timeout_i),
    .line_state_i(line_state_i),
    .usb_endpt_i (usb_endpt_i),
    .usb_tuser_i (usb_tuser_i),
    .phy_state_i (phy_state_i),
    .usb_state_i (usb_state_i),
    .ctl_state_i (ctl_state_i),
    .usb_error_i (usb_error_i),
    .blk_state_i (blk_state_i),
    .rec_ready_i (rec_ready),
    .rec_valid_o (rec_valid),
    .rec_data_o  (rec_data),
    .rec_last_o  (rec_last)
  );

  telemetry_fifo u_fifo (
    .clock     (clock),
    .reset     (reset),
    .wr_valid_i(rec_valid),
    .wr_data_i (rec_data),
    .wr_last_i (rec_last),
    .wr_ready_o(rec_ready),
    .rd_valid_o(word_valid),
    .rd_ready_i(word_ready),
    .rd_data_o (word_data),
    .rd_last_o (word_last),
    .level_o   (level_o)
  );

  telemetry_bulk_tx u_bulk_tx (
    .clock       (clock),
    .reset       (reset),
    .usb_enum_i  (usb_enum_i),
    .select_i    (select_i),
    .start_i     (start_i),
    .endpt_i     (endpt_i),
    .word_valid_i(word_valid),
    .word_ready_o(word_ready),
    .word_data_i (word_data),
    .word_last_i (word_last),
    .tvalid_o    (tvalid_o),
    .tready_i    (tready_i),
    .tdata_o     (tdata_o),
    .tlast_o     (tlast_o)
  );

endmodule

// File: bench/telemetry_checker.sv
`include "telemetry_settings.svh"

module telemetry_checker (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        usb_enum_i,
  input  logic                        select_i,
  input  logic                        start_i,
  input  usb_status_pkg::usb_nibble_t endpt_i,
  input  logic                        tvalid_i,
  input  logic                        tready_i,
  input  telemetry_pkg::byte_t        tdata_i,
  input  logic                        tlast_i
);

  logic [31:0] expected_q [$];
  int          error_count = 0;
  int          record_count;
  logic        armed;
  logic [1:0]  lane;
  logic [31:0] assembled;
  logic [31:0] expected;
  logic        expected_last;

  task add_expected(input logic [31:0] rec);
    expected_q.push_back(rec);
  endtask

  function int pending();
    return expected_q.size();
  endfunction

  // Records arrive lowest byte first, so each byte shifts in from the top
  always @(posedge clock) begin
    if (reset) begin
      armed        = 1'b0;
      lane         = 2'd0;
      record_count = 0;
      assembled    = '0;
    end else begin
      if (tvalid_i && tready_i) begin
        if (!armed) begin
          $display("Byte sent on the bulk-IN stream without a start request");
          error_count++;
        end
        assembled = {tdata_i, assembled[31:8]};
        if (lane == 2'd3) begin
          expected_last = ((record_count % `TLM_PACKET_SIZE) == `TLM_PACKET_SIZE - 1);
          if (expected_q.size() == 0) begin
            $display("Record %h received when no record was expected", assembled);
            error_count++;
          end else begin
            expected = expected_q.pop_front();
            if (assembled != expected) begin
              $display("MISMATCH rec_data expected %h got %h", expected, assembled);
              error_count++;
            end
          end
          if (tlast_i != expected_last) begin
            $display("MISMATCH tlast_o expected %h got %h", expected_last, tlast_i);
            error_count++;
          end
          record_count++;
        end else if (tlast_i) begin
          $display("tlast was high before the fourth byte of a record");
          error_count++;
        end
        // Packet end closes the selection
        if (tlast_i) begin
          armed = 1'b0;
        end
        lane = lane + 2'd1;
      end
      if (usb_enum_i && start_i && select_i && (endpt_i == `TLM_ENDPOINT)) begin
        armed = 1'b1;
      end
    end
  end

endmodule

// File: bench/bulk_telemetry_tb.sv
`include "telemetry_settings.svh"

module bulk_telemetry_tb;

  import usb_status_pkg::*;
  import telemetry_pkg::*;

  localparam int STEPS       = 64;
  localparam int DRAIN_LIMIT = 20000;
  localparam int IDLE_CYCLES = 8;
  localparam int IDLE_LIMIT  = 2000;

  logic        clock;
  logic        reset;
  logic        usb_enum;
  logic        usb_reset;
  logic        usb_sof;
  logic        usb_sent;
  logic        usb_recv;
  logic        tok_recv;
  logic        high_speed;
  logic        crc_error;
  logic        timeout;
  line_state_t line_state;
  usb_nibble_t usb_endpt;
  usb_nibble_t usb_tuser;
  usb_nibble_t phy_state;
  usb_nibble_t usb_state;
  usb_nibble_t ctl_state;
  usb_error_t  usb_error;
  blk_onehot_t blk_state;
  logic        select;
  logic        start;
  usb_nibble_t endpt;
  logic        tready;
  logic        tvalid;
  byte_t       tdata;
  logic        tlast;
  level_t      level;

  logic [79:0] steps [STEPS];
  logic [79:0] st;
  logic [31:0] rnd;
  integer      seed;
  logic        rand_ready;
  logic        done;
  int          errors;
  int          errors_before;
  int          tests_run;
  int          tests_failed;
  int          total;
  int          i;

  bulk_telemetry_top u_dut (
    .clock       (clock),
    .reset       (reset),
    .usb_enum_i  (usb_enum),
    .usb_reset_i (usb_reset),
    .usb_sof_i   (usb_sof),
    .usb_sent_i  (usb_sent),
    .usb_recv_i  (usb_recv),
    .tok_recv_i  (tok_recv),
    .high_speed_i(high_speed),
    .crc_error_i (crc_error),
    .timeout_i   (timeout),
    .line_state_i(line_state),
    .usb_endpt_i (usb_endpt),
    .usb_tuser_i (usb_tuser),
    .phy_state_i (phy_state),
    .usb_state_i (usb_state),
    .ctl_state_i (ctl_state),
    .usb_error_i (usb_error),
    .blk_state_i (blk_state),
    .select_i    (select),
    .start_i     (start),
    .endpt_i     (endpt),
    .tready_i    (tready),
    .tvalid_o    (tvalid),
    .tdata_o     (tdata),
    .tlast_o     (tlast),
    .level_o     (level)
  );

  telemetry_checker u_checker (
    .clock     (clock),
    .reset     (reset),
    .usb_enum_i(usb_enum),
    .select_i  (select),
    .start_i   (start),
    .endpt_i   (endpt),
    .tvalid_i  (tvalid),
    .tready_i  (tready),
    .tdata_i   (tdata),
    .tlast_i   (tlast)
  );

  always #20 clock = ~clock;

  always @(negedge clock) begin
    rnd = $random(seed);
    tready = rand_ready ? rnd[0] : 1'b1;
  end

  task apply_fields(input logic [79:0] s);
    usb_enum   = s[75];
    usb_reset  = s[74];
    usb_sent   = s[73];
    usb_recv   = s[72];
    tok_recv   = s[71];
    high_speed = s[70];
    crc_error  = s[69];
    timeout    = s[68];
    line_state = s[65:64];
    usb_endpt  = s[63:60];
    usb_tuser  = s[59:56];
    phy_state  = s[55:52];
    usb_state  = s[51:48];
    ctl_state  = s[47:44];
    usb_error  = s[42:40];
    blk_state  = s[39:32];
  endtask

  task pulse_sof(input logic [31:0] count);
    repeat (count) begin
      usb_sof = 1'b1;
      @(negedge clock);
      usb_sof = 1'b0;
      @(negedge clock);
    end
  endtask

  // One new record per cycle, phy state steps through all sixteen codes
  task phy_burst(input logic [79:0] s);
    apply_fields(s);
    for (int k = 0; k < 16; k++) begin
      phy_state = k[3:0];
      u_checker.add_expected({s[31:4], k[3:0]});
      @(negedge clock);
    end
  endtask

  // A start request is only meaningful once the stream has gone quiet
  task wait_stream_idle();
    int quiet;
    int n;
    quiet = 0;
    n = 0;
    while (quiet < IDLE_CYCLES && n < IDLE_LIMIT) begin
      @(negedge clock);
      quiet = tvalid ? 0 : quiet + 1;
      n++;
    end
    if (quiet < IDLE_CYCLES) begin
      $display("Timed out waiting for the byte stream to go idle");
      errors++;
    end
  endtask

  task drain_stream();
    int n;
    n = 0;
    while (u_checker.pending() != 0 && n < DRAIN_LIMIT) begin
      if (!tvalid) begin
        select = 1'b1;
        endpt  = `TLM_ENDPOINT;
        start  = 1'b1;
      end else begin
        start = 1'b0;
      end
      @(negedge clock);
      n++;
    end
    start = 1'b0;
    if (n >= DRAIN_LIMIT) begin
      $display("Timed out waiting for %0d expected records", u_checker.pending());
      errors++;
    end else if (level != level_t'(0)) begin
      $display("MISMATCH level_o expected %h got %h", level_t'(0), level);
      errors++;
    end
  endtask

  task close_test(input logic [31:0] num);
    total = errors + u_checker.error_count;
    tests_run++;
    if (total != errors_before) begin
      tests_failed++;
      $display("test %0d failed", num);
    end else begin
      $display("test %0d passed", num);
    end
    errors_before = total;
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    usb_sof = 1'b0;
    select = 1'b0;
    start = 1'b0;
    endpt = '0;
    tready = 1'b1;
    apply_fields({12'h000, 4'h1, 24'h000000, 8'h01, 32'h0});
    seed = 32'h3537;
    rand_ready = 1'b0;
    errors = 0;
    errors_before = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int j = 0; j < STEPS; j++) begin
      steps[j] = '1;
    end
    $readmemh("bench/telemetry_tests.txt", steps);

    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    i = 0;
    done = 1'b0;
    while (!done && i < STEPS) begin
      st = steps[i];
      case (st[79:76])
        4'h0: begin
          apply_fields(st);
          @(negedge clock);
        end
        4'h1: pulse_sof(st[31:0]);
        4'h2: u_checker.add_expected(st[31:0]);
        4'h3: begin
          wait_stream_idle();
          select = st[4];
          endpt  = st[3:0];
          start  = 1'b1;
          @(negedge clock);
          start  = 1'b0;
        end
        4'h4: drain_stream();
        4'h5: rand_ready = st[0];
        4'h6: close_test(st[31:0]);
        4'h7: repeat (st[31:0]) @(negedge clock);
        4'h8: phy_burst(st);
        default: done = 1'b1;
      endcase
      i++;
    end

    total = errors + u_checker.error_count;
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: bench/telemetry_tests.txt
// kind_flags_line_endpt.tuser.phy.state.ctl.error_blk_arg in hex, flags enum.rst.sent.recv.tok.hs.crc.tmo
// kinds 0 set 1 sof burst 2 expect 3 start 4 drain 5 tready mode 6 end test 7 idle 8 phy burst F end
0_00_1_500000_01_00000000
0_80_1_500000_01_00000000
0_80_2_500000_01_00000000
4_00_0_000000_00_00000000
6_00_0_000000_00_00000001
0_80_2_539040_01_00000000
2_00_0_000000_00_45300049
3_00_0_000000_00_00000012
4_00_0_000000_00_00000000
6_00_0_000000_00_00000002
0_88_2_539040_01_00000000
2_00_0_000000_00_45303049
0_98_2_539040_01_00000000
2_00_0_000000_00_45304049
0_B8_2_539040_01_00000000
2_00_0_000000_00_45305049
0_B8_2_539840_01_00000000
2_00_0_000000_00_45386049
0_B9_2_539840_01_00000000
2_00_0_000000_00_45387049
0_82_2_539045_01_00000000
2_00_0_000000_00_4530D049
0_82_2_539045_10_00000000
2_00_0_000000_00_4530D449
0_82_2_539045_12_00000000
2_00_0_000000_00_4530D749
4_00_0_000000_00_00000000
6_00_0_000000_00_00000003
1_00_0_000000_00_00000020
2_00_0_000000_00_4530DF49
2_00_0_000000_00_4530D749
0_86_2_539045_12_00000000
1_00_0_000000_00_00000100
2_00_0_000000_00_4530DF49
2_00_0_000000_00_4530D749
4_00_0_000000_00_00000000
6_00_0_000000_00_00000004
0_86_2_53A045_12_00000000
2_00_0_000000_00_4530D74A
0_86_2_53B045_12_00000000
2_00_0_000000_00_4530D74B
0_86_2_53C045_12_00000000
2_00_0_000000_00_4530D74C
0_86_2_53D045_12_00000000
2_00_0_000000_00_4530D74D
3_00_0_000000_00_00000013
7_00_0_000000_00_00000028
3_00_0_000000_00_00000002
7_00_0_000000_00_00000028
3_00_0_000000_00_00000012
7_00_0_000000_00_00000028
4_00_0_000000_00_00000000
6_00_0_000000_00_00000005
5_00_0_000000_00_00000001
8_86_2_530045_12_4530D740
4_00_0_000000_00_00000000
5_00_0_000000_00_00000000
6_00_0_000000_00_00000006
F_00_0_000000_00_00000000

// File: flist.f
+incdir+include
hw/usb_status_pkg.sv
hw/telemetry_pkg.sv
hw/telemetry_snapshot.sv
hw/telemetry_fifo.sv
hw/telemetry_bulk_tx.sv
hw/bulk_telemetry_top.sv
bench/telemetry_checker.sv
bench/bulk_telemetry_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
TOP        ?= bulk_telemetry_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
